//--- tiles_pkg.sv
package tiles_pkg;

	////////////////////////////////////////////////////////////
	// track geometry

	localparam int num_lanes   = 4;
	localparam int num_rows    = 4;
	localparam int pos_w       = 9;
	localparam int track_len   = 360;	// positions 0..359, then wrap
	localparam int hit_lo      = 340;
	localparam int hit_hi      = 359;
	localparam int row_spacing = 90;

	// lane mask per row, bit n = lane n
	localparam logic [num_rows-1:0][num_lanes-1:0] row_pattern = {
		4'b1000,	// row 3
		4'b0100,	// row 2
		4'b1010,	// row 1
		4'b0101		// row 0
	};

	localparam int score_w = 16;

	////////////////////////////////////////////////////////////
	// keyboard and game encodings

	typedef enum logic [7:0] {
		key_s     = 8'h1B,
		key_d     = 8'h23,
		key_j     = 8'h3B,
		key_k     = 8'h42,
		key_enter = 8'h5A,
		key_break = 8'hF0
	} key_code_t;

	typedef enum logic {st_title, st_play} game_state_t;

endpackage

//--- ps2_rx.sv
`timescale 1ns/100ps

module ps2_rx import tiles_pkg::*; (
	input  logic      clock,
	input  logic      rst_n,
	input  logic      ps2_clk,
	input  logic      ps2_data,
	output key_code_t code,
	output logic      is_break,
	output logic      code_valid
);

	logic [1:0]  clk_sync;
	logic [1:0]  data_sync;
	logic        clk_prev;
	logic        fall;
	logic [3:0]  bit_cnt;
	logic [9:0]  frame;	// start, 8 data, parity
	logic [10:0] full;
	logic        done;
	logic        frame_ok;
	logic        is_prefix;
	logic        brk_pend;

	////////////////////////////////////////////////////////////
	// line synchronizers, idle high

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			clk_sync  <= 2'b11;
			data_sync <= 2'b11;
			clk_prev  <= 1'b1;
		end else begin
			clk_sync  <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
			clk_prev  <= clk_sync[1];
		end
	end

	assign fall = clk_prev && !clk_sync[1];

	// stop bit is still on the data line at the last edge
	assign full      = {data_sync[1], frame};
	assign done      = fall && (bit_cnt == 4'd10);
	assign frame_ok  = !full[0] && (^full[9:1]) && full[10];	// odd parity over data+parity
	assign is_prefix = (full[8:1] == key_break);

	always_ff @(posedge clock) begin
		if (fall)
			frame <= {data_sync[1], frame[9:1]};	// lsb first
	end

	////////////////////////////////////////////////////////////
	// frame counter and event strobe

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			bit_cnt    <= '0;
			brk_pend   <= 1'b0;
			code_valid <= 1'b0;
		end else begin
			code_valid <= 1'b0;
			if (done) begin
				bit_cnt <= '0;
				if (frame_ok) begin
					if (is_prefix) begin
						brk_pend <= 1'b1;	// wait for the released key
					end else begin
						brk_pend   <= 1'b0;
						code_valid <= 1'b1;
					end
				end
			end else if (fall) begin
				bit_cnt <= bit_cnt + 4'd1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (done && frame_ok && !is_prefix) begin
			code     <= key_code_t'(full[8:1]);
			is_break <= brk_pend;
		end
	end

endmodule

//--- tick_gen.sv
`timescale 1ns/100ps

module tick_gen #(
	parameter int STEP_DIV = 1_000_000,
	parameter int SEC_DIV  = 100_000_000
) (
	input  logic clock,
	input  logic rst_n,
	output logic step_tick,
	output logic sec_tick
);

	localparam int div_max = (STEP_DIV > SEC_DIV) ? STEP_DIV : SEC_DIV;
	localparam int cnt_w   = $clog2(div_max + 1);
	localparam int divs [2] = '{STEP_DIV, SEC_DIV};

	logic [1:0] tick;

	// one free-running divider per enable
	for (genvar i = 0; i < 2; i++) begin : g_div
		logic [cnt_w-1:0] cnt;

		always_ff @(posedge clock) begin
			if (!rst_n)
				cnt <= '0;
			else if (tick[i])
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;
		end

		assign tick[i] = (cnt == cnt_w'(divs[i] - 1));	// last count of the period
	end

	assign step_tick = tick[0];
	assign sec_tick  = tick[1];

endmodule

//--- tile_rows.sv
`timescale 1ns/100ps

module tile_rows import tiles_pkg::*; (
	input  logic                             clock,
	input  logic                             rst_n,
	input  logic                             step_tick,
	output logic [num_rows-1:0][pos_w-1:0]   row_pos
);

	localparam logic [pos_w-1:0] last_pos = pos_w'(track_len - 1);

	// next position along the track
	function automatic logic [pos_w-1:0] advance(input logic [pos_w-1:0] pos);
		logic [pos_w-1:0] nxt;
		if (pos == last_pos)
			nxt = '0;
		else
			nxt = pos + 1'b1;
		return nxt;
	endfunction

	// row k starts 90 positions behind row k-1
	function automatic logic [pos_w-1:0] start_pos(input int k);
		int p;
		p = row_spacing * (num_rows - 1 - k);
		return pos_w'(p);
	endfunction

	////////////////////////////////////////////////////////////
	// row counters, moving in every game state

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int k = 0; k < num_rows; k++)
				row_pos[k] <= start_pos(k);
		end else if (step_tick) begin
			for (int k = 0; k < num_rows; k++)
				row_pos[k] <= advance(row_pos[k]);
		end
	end

endmodule

//--- game_ctrl.sv
`timescale 1ns/100ps

module game_ctrl import tiles_pkg::*; #(
	parameter int GAME_SECONDS = 60
) (
	input  logic                           clock,
	input  logic                           rst_n,
	input  key_code_t                      code,
	input  logic                           is_break,
	input  logic                           code_valid,
	input  logic                           step_tick,
	input  logic                           sec_tick,
	input  logic [num_rows-1:0][pos_w-1:0] row_pos,
	output logic [score_w-1:0]             score,
	output logic [6:0]                     seconds,
	output logic                           playing,
	output logic [num_lanes-1:0]           lane_flash
);

	localparam int lane_w = $clog2(num_lanes);

	game_state_t         state;
	logic                make;
	logic                lane_key;
	logic [lane_w-1:0]   lane;
	logic [num_rows-1:0] in_window;
	logic                lane_hit;
	logic                round_over;

	assign make       = code_valid && !is_break;	// releases never count
	assign round_over = (seconds == 7'(GAME_SECONDS));
	assign playing    = (state == st_play);

	////////////////////////////////////////////////////////////
	// key to lane, hit judging

	always_comb begin
		lane_key = 1'b1;
		case (code)
			key_s:   lane = lane_w'(0);
			key_d:   lane = lane_w'(1);
			key_j:   lane = lane_w'(2);
			key_k:   lane = lane_w'(3);
			default: begin
				lane     = '0;
				lane_key = 1'b0;
			end
		endcase
	end

	always_comb begin
		lane_hit = 1'b0;
		for (int r = 0; r < num_rows; r++) begin
			in_window[r] = (row_pos[r] >= pos_w'(hit_lo)) && (row_pos[r] <= pos_w'(hit_hi));
			if (in_window[r] && row_pattern[r][lane])
				lane_hit = 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// round state, timer, score

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state      <= st_title;
			score      <= '0;
			seconds    <= '0;
			lane_flash <= '0;
		end else begin
			if (step_tick)
				lane_flash <= '0;

			case (state)
				st_title: begin
					if (make && code == key_enter) begin
						score      <= '0;
						seconds    <= '0;
						lane_flash <= '0;
						state      <= st_play;
					end
				end
				st_play: begin
					if (round_over) begin
						state <= st_title;
					end else begin
						if (sec_tick)
							seconds <= seconds + 7'd1;
						if (make && lane_key) begin
							lane_flash <= '0;	// a miss clears the old flash
							if (lane_hit) begin
								score            <= score + 1'b1;
								lane_flash[lane] <= 1'b1;
							end
						end
					end
				end
				default: state <= st_title;
			endcase
		end
	end

endmodule

//--- tiles_top.sv
`timescale 1ns/100ps

module tiles_top import tiles_pkg::*; #(
	parameter int STEP_DIV     = 1_000_000,	// 10 ms per step at 100 MHz
	parameter int SEC_DIV      = 100_000_000,
	parameter int GAME_SECONDS = 60
) (
	input  logic                           clock,
	input  logic                           rst_n,
	input  logic                           ps2_clk,
	input  logic                           ps2_data,
	output logic [num_rows-1:0][pos_w-1:0] row_pos,
	output logic [score_w-1:0]             score,
	output logic [6:0]                     seconds,
	output logic                           playing,
	output logic [num_lanes-1:0]           lane_flash
);

	logic      step_tick;
	logic      sec_tick;
	key_code_t code;
	logic      is_break;
	logic      code_valid;

	tick_gen #(
		.STEP_DIV (STEP_DIV),
		.SEC_DIV  (SEC_DIV)
	) tick_gen (
		.clock     (clock),
		.rst_n     (rst_n),
		.step_tick (step_tick),
		.sec_tick  (sec_tick)
	);

	ps2_rx ps2_rx (
		.clock      (clock),
		.rst_n      (rst_n),
		.ps2_clk    (ps2_clk),
		.ps2_data   (ps2_data),
		.code       (code),
		.is_break   (is_break),
		.code_valid (code_valid)
	);

	tile_rows tile_rows (
		.clock     (clock),
		.rst_n     (rst_n),
		.step_tick (step_tick),
		.row_pos   (row_pos)
	);

	game_ctrl #(
		.GAME_SECONDS (GAME_SECONDS)
	) game_ctrl (
		.clock      (clock),
		.rst_n      (rst_n),
		.code       (code),
		.is_break   (is_break),
		.code_valid (code_valid),
		.step_tick  (step_tick),
		.sec_tick   (sec_tick),
		.row_pos    (row_pos),
		.score      (score),
		.seconds    (seconds),
		.playing    (playing),
		.lane_flash (lane_flash)
	);

endmodule

//--- tb_tiles.sv
`timescale 1ns/100ps

module tb_tiles import tiles_pkg::*; ();

	localparam int step_div     = 2000;
	localparam int sec_div      = 5000;
	localparam int game_seconds = 4;
	localparam int half_period  = 20;	// ps2 half period in system cycles
	localparam int num_presses  = 8;
	localparam int num_frames   = num_presses + 10;
	localparam int cycle_limit  =
		2 * (100 * step_div + num_frames * 500 + 2 * game_seconds * sec_div);
	localparam int reset_pos [num_rows] = '{270, 180, 90, 0};

	logic                           clock;
	logic                           rst_n;
	logic                           ps2_clk;
	logic                           ps2_data;
	logic [num_rows-1:0][pos_w-1:0] row_pos;
	logic [score_w-1:0]             score;
	logic [6:0]                     seconds;
	logic                           playing;
	logic [num_lanes-1:0]           lane_flash;

	logic [num_rows-1:0][pos_w-1:0] last_rows;
	integer seed;
	int     errors;
	int     cycles;
	int     phase;	// cycles since the last row step
	int     exp_score;

	tiles_top #(
		.STEP_DIV     (step_div),
		.SEC_DIV      (sec_div),
		.GAME_SECONDS (game_seconds)
	) DUT (
		.clock      (clock),
		.rst_n      (rst_n),
		.ps2_clk    (ps2_clk),
		.ps2_data   (ps2_data),
		.row_pos    (row_pos),
		.score      (score),
		.seconds    (seconds),
		.playing    (playing),
		.lane_flash (lane_flash)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	task automatic compare(input string name, input int expected, input int got);
		if (expected != got) begin
			errors++;
			$display("Mismatch %0t %s expected %0d got %0d", $time, name, expected, got);
		end
	endtask

	// does a press in this lane land on a tile
	function automatic bit press_scores(input int lane,
			input logic [num_rows-1:0][pos_w-1:0] pos);
		bit hit;
		hit = 1'b0;
		for (int r = 0; r < num_rows; r++)
			if (row_pattern[r][lane] && int'(pos[r]) >= hit_lo && int'(pos[r]) <= hit_hi)
				hit = 1'b1;
		return hit;
	endfunction

	function automatic logic [7:0] lane_code(input int lane);
		case (lane)
			0:       return key_s;
			1:       return key_d;
			2:       return key_j;
			default: return key_k;
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// ps2 host model

	task automatic send_frame(input logic [7:0] data, input bit bad_parity);
		logic [10:0] frame;
		frame = {1'b1, ~(^data) ^ bad_parity, data, 1'b0};	// stop, parity, data, start
		for (int i = 0; i < 11; i++) begin
			@(posedge clock);
			ps2_data <= frame[i];
			repeat (half_period) @(posedge clock);
			ps2_clk <= 1'b0;
			repeat (half_period) @(posedge clock);
			ps2_clk <= 1'b1;
		end
		repeat (10) @(posedge clock);	// sync and register latency
	endtask

	// keep clear of window edges and of the next step
	task automatic wait_safe;
		bit near;
		int p;
		do begin
			near = (phase > step_div - 500);
			for (int r = 0; r < num_rows; r++) begin
				p = int'(row_pos[r]);
				if ((p >= hit_lo - 2 && p <= hit_lo + 1) || p >= hit_hi - 1 ||
						p <= (hit_hi + 2) % track_len)
					near = 1'b1;
			end
			if (near)
				@(posedge clock);
		end while (near);
	endtask

	task automatic press_lane(input int lane);
		bit hit;
		wait_safe();
		hit = press_scores(lane, row_pos);
		send_frame(lane_code(lane), 1'b0);
		if (hit)
			exp_score++;
		compare("score", exp_score, int'(score));
		compare("lane_flash", hit ? (1 << lane) : 0, int'(lane_flash));
	endtask

	////////////////////////////////////////////////////////////
	// row stepping check and timeout

	always @(posedge clock) begin
		last_rows <= row_pos;
		phase     <= phase + 1;
		if (rst_n && row_pos[0] != last_rows[0]) begin
			phase <= 0;
			for (int k = 0; k < num_rows; k++)
				compare($sformatf("row_pos[%0d]", k), (int'(last_rows[k]) + 1) % track_len,
					int'(row_pos[k]));
		end
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles == cycle_limit) begin
			$display("Timeout, the run did not end within %0d cycles", cycle_limit);
			$display("Finished with errors");
			$finish;
		end
	end

	initial begin
		int lane;
		int gap;
		int prev_sec;
		seed      = 32'hd371;
		exp_score = 0;
		rst_n    <= 1'b0;
		ps2_clk  <= 1'b1;
		ps2_data <= 1'b1;
		repeat (10) @(posedge clock);
		rst_n <= 1'b1;
		@(posedge clock);
		compare("playing", 0, int'(playing));
		compare("score", 0, int'(score));
		compare("lane_flash", 0, int'(lane_flash));
		for (int k = 0; k < num_rows; k++)
			compare($sformatf("row_pos[%0d]", k), reset_pos[k], int'(row_pos[k]));

		// title keys must not score while row 0 sits in the window
		while (int'(row_pos[0]) != hit_lo + 2)
			@(posedge clock);
		send_frame(lane_code(0), 1'b0);
		send_frame(lane_code(2), 1'b0);
		compare("playing", 0, int'(playing));
		compare("score", 0, int'(score));
		compare("lane_flash", 0, int'(lane_flash));
		send_frame(key_enter, 1'b0);
		compare("playing", 1, int'(playing));
		compare("score", 0, int'(score));

		for (int i = 0; i < num_presses; i++) begin
			lane = $unsigned($random(seed)) % num_lanes;
			gap  = $unsigned($random(seed)) % 128;
			repeat (gap) @(posedge clock);
			press_lane(lane);
		end

		// rejected frames that would hit if accepted
		wait_safe();
		send_frame(lane_code(0), 1'b1);
		compare("score", exp_score, int'(score));
		wait_safe();
		send_frame(key_break, 1'b0);
		send_frame(lane_code(0), 1'b0);
		compare("score", exp_score, int'(score));
		wait_safe();
		send_frame(8'h1C, 1'b0);
		compare("score", exp_score, int'(score));
		compare("playing", 1, int'(playing));

		////////////////////////////////////////////////////////////
		// round timer and a second round

		prev_sec = int'(seconds);
		while (playing) begin
			@(posedge clock);
			if (int'(seconds) != prev_sec) begin
				compare("seconds", prev_sec + 1, int'(seconds));
				prev_sec = int'(seconds);
			end
		end
		compare("seconds", game_seconds, int'(seconds));
		send_frame(key_enter, 1'b0);
		compare("playing", 1, int'(playing));
		compare("score", 0, int'(score));

		$display("Error count: %0d", errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

//--- sim.f
tiles_pkg.sv
ps2_rx.sv
tick_gen.sv
tile_rows.sv
game_ctrl.sv
tiles_top.sv
tb_tiles.sv

//--- Makefile
.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -f sim.f --top-module tb_tiles -o tb_tiles
	./obj_dir/tb_tiles | tee sim.log
	grep -qx "Finished with no errors" sim.log

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module tiles_top

clean:
	rm -rf obj_dir sim.log
